// ==== common/noc_pkg.sv ====
package noc_pkg;

	// router ports.
	localparam int NUM_PORTS = 5;

	// mesh coordinate and payload widths.
	localparam int COORD_W = 3;
	localparam int DATA_W  = 16;

	// port number, also used as route and grant select.
	typedef logic [2:0] port_idx_t;

	localparam port_idx_t PORT_N = 3'd0; // toward larger y.
	localparam port_idx_t PORT_S = 3'd1; // toward smaller y.
	localparam port_idx_t PORT_W = 3'd2; // toward smaller x.
	localparam port_idx_t PORT_E = 3'd3; // toward larger x.
	localparam port_idx_t PORT_L = 3'd4; // local core.

	// one flit on a link, 23 bits wide.
	// every flit carries the destination; only the head's copy is routed.
	typedef struct packed {
		logic               head;  // first flit of a packet.
		logic [COORD_W-1:0] dst_y; // destination row.
		logic [COORD_W-1:0] dst_x; // destination column.
		logic [DATA_W-1:0]  data;  // payload word.
	} flit_t;

	// next-hop request from a route stage to the arbiters.
	typedef struct packed {
		logic      valid; // packet waiting for its output.
		port_idx_t port;  // requested output.
	} route_t;

endpackage

// ==== hw/flit_fifo.sv ====
`timescale 1ns/1ps

module flit_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic           clk,
	input  logic           reset_i,
	input  logic           wr_i,
	input  noc_pkg::flit_t wr_flit_i,
	input  logic           pop_i,
	output noc_pkg::flit_t head_flit_o,
	output logic           not_empty_o,
	output logic           credit_o
);

	import noc_pkg::*;

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	flit_t             mem [FIFO_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;
	logic              full;

	assign full        = (count == CNT_W'(FIFO_DEPTH));
	assign not_empty_o = (count != '0);
	assign head_flit_o = mem[rd_ptr]; // oldest flit, read without a pop.

	always_ff @(posedge clk) begin
		if (wr_i) begin
			mem[wr_ptr] <= wr_flit_i;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			credit_o <= 1'b0;
		end else begin
			if (wr_i) begin
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop_i) begin
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({wr_i, pop_i})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			credit_o <= pop_i; // one credit per removed flit, next cycle.
		end
	end

	// the upstream sender only holds credits for free slots.
	a_no_overflow: assert property (@(posedge clk) disable iff (reset_i)
		!(wr_i && full))
		else $error("flit_fifo: write into a full buffer, credit rule broken");

	// a grant must never drain a buffer that has nothing in it.
	a_no_underflow: assert property (@(posedge clk) disable iff (reset_i)
		pop_i |-> not_empty_o)
		else $error("flit_fifo: pop from an empty buffer");

endmodule

// ==== hw/route/route_decode.sv ====
`timescale 1ns/1ps

module route_decode #(
	parameter int                PKT_FLITS = 4,
	parameter int                ROUTER_X  = 2,
	parameter int                ROUTER_Y  = 2,
	parameter noc_pkg::port_idx_t IN_PORT  = noc_pkg::PORT_N
) (
	input  logic            clk,
	input  logic            reset_i,
	input  noc_pkg::flit_t  head_flit_i,
	input  logic            not_empty_i,
	input  logic            sent_i,
	output noc_pkg::route_t route_o
);

	import noc_pkg::*;

	localparam int CNT_W = (PKT_FLITS > 1) ? $clog2(PKT_FLITS) : 1;

	localparam logic [COORD_W-1:0] MY_X = COORD_W'(ROUTER_X);
	localparam logic [COORD_W-1:0] MY_Y = COORD_W'(ROUTER_Y);

	port_idx_t        next_hop;
	logic             load_route;
	logic [CNT_W-1:0] flit_cnt;
	logic             last_flit;

	// yx order: resolve the row first, then the column.
	always_comb begin
		if (head_flit_i.dst_y > MY_Y) begin
			next_hop = PORT_N;
		end else if (head_flit_i.dst_y < MY_Y) begin
			next_hop = PORT_S;
		end else if (head_flit_i.dst_x > MY_X) begin
			next_hop = PORT_E;
		end else if (head_flit_i.dst_x < MY_X) begin
			next_hop = PORT_W;
		end else begin
			next_hop = PORT_L;
		end
	end

	assign load_route = !route_o.valid && not_empty_i && head_flit_i.head;
	assign last_flit  = sent_i && (flit_cnt == CNT_W'(PKT_FLITS - 1));

	always_ff @(posedge clk) begin
		if (reset_i) begin
			route_o.valid <= 1'b0;
			route_o.port  <= PORT_N;
			flit_cnt      <= '0;
		end else begin
			if (load_route) begin
				route_o.valid <= 1'b1;
				route_o.port  <= next_hop; // held for the whole packet.
			end else if (last_flit) begin
				route_o.valid <= 1'b0;
			end
			if (last_flit) begin
				flit_cnt <= '0;
			end else if (sent_i) begin
				flit_cnt <= flit_cnt + 1'b1; // packet tracker.
			end
		end
	end

	// a flit arriving from a neighbour never turns back toward it
	generate
		if (IN_PORT != PORT_L) begin : g_no_u_turn
			a_no_u_turn: assert property (@(posedge clk) disable iff (reset_i)
				route_o.valid |-> (route_o.port != IN_PORT))
				else $error("route_decode: packet routed back out of port %0d", IN_PORT);
		end
	endgenerate

	// flits only leave while this input holds a route.
	a_sent_routed: assert property (@(posedge clk) disable iff (reset_i)
		sent_i |-> route_o.valid)
		else $error("route_decode: flit sent without a valid route");

endmodule

// ==== hw/arbiter/output_arbiter.sv ====
`timescale 1ns/1ps

module output_arbiter #(
	parameter int                 FIFO_DEPTH = 4,
	parameter int                 PKT_FLITS  = 4,
	parameter noc_pkg::port_idx_t OUT_PORT   = noc_pkg::PORT_N
) (
	input  logic                                      clk,
	input  logic                                      reset_i,
	input  noc_pkg::route_t [noc_pkg::NUM_PORTS-1:0] routes_i,
	input  logic [noc_pkg::NUM_PORTS-1:0]             not_empty_i,
	input  logic                                      credit_i,
	output logic                                      grant_valid_o,
	output noc_pkg::port_idx_t                        grant_src_o,
	output logic                                      send_o
);

	import noc_pkg::*;

	localparam int CNT_W = (PKT_FLITS > 1) ? $clog2(PKT_FLITS) : 1;
	localparam int CRD_W = $clog2(FIFO_DEPTH + 1);

	logic [NUM_PORTS-1:0] req;
	port_idx_t            rr_ptr;
	port_idx_t            pick_src;
	logic                 pick_valid;
	logic [CNT_W-1:0]     flit_cnt;
	logic [CRD_W-1:0]     credit_cnt;

	always_comb begin
		for (int i = 0; i < NUM_PORTS; i++) begin
			req[i] = routes_i[i].valid && (routes_i[i].port == OUT_PORT);
		end
	end

	// scan from the far end so the closest request to the pointer wins
	always_comb begin
		int idx;
		pick_valid = 1'b0;
		pick_src   = PORT_N;
		for (int k = NUM_PORTS - 1; k >= 0; k--) begin
			idx = int'(rr_ptr) + k;
			if (idx >= NUM_PORTS) begin
				idx = idx - NUM_PORTS;
			end
			if (req[idx]) begin
				pick_valid = 1'b1;
				pick_src   = port_idx_t'(idx);
			end
		end
	end

	// flit leaves when granted, buffered and downstream has room.
	assign send_o = grant_valid_o && not_empty_i[grant_src_o] && (credit_cnt != '0);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			grant_valid_o <= 1'b0;
			grant_src_o   <= PORT_N;
			rr_ptr        <= PORT_N;
			flit_cnt      <= '0;
		end else if (!grant_valid_o) begin
			if (pick_valid) begin
				grant_valid_o <= 1'b1;
				grant_src_o   <= pick_src;
			end
		end else if (send_o) begin
			if (flit_cnt == CNT_W'(PKT_FLITS - 1)) begin
				grant_valid_o <= 1'b0; // whole packet out.
				flit_cnt      <= '0;
				rr_ptr        <= (grant_src_o == port_idx_t'(NUM_PORTS - 1)) ?
					PORT_N : grant_src_o + 1'b1;
			end else begin
				flit_cnt <= flit_cnt + 1'b1;
			end
		end
	end

	// free slots in the downstream buffer.
	always_ff @(posedge clk) begin
		if (reset_i) begin
			credit_cnt <= CRD_W'(FIFO_DEPTH);
		end else begin
			case ({send_o, credit_i})
				2'b10:   credit_cnt <= credit_cnt - 1'b1;
				2'b01:   credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	// downstream returns no more credits than flits it was sent.
	a_credit_bound: assert property (@(posedge clk) disable iff (reset_i)
		(credit_i && !send_o) |-> (credit_cnt < CRD_W'(FIFO_DEPTH)))
		else $error("output_arbiter %0d: credit count above FIFO_DEPTH", OUT_PORT);

endmodule

// ==== hw/crossbar.sv ====
`timescale 1ns/1ps

module crossbar (
	input  logic                                         clk,
	input  logic                                         reset_i,
	input  noc_pkg::flit_t     [noc_pkg::NUM_PORTS-1:0] flits_i,
	input  logic               [noc_pkg::NUM_PORTS-1:0] grant_valid_i,
	input  noc_pkg::port_idx_t [noc_pkg::NUM_PORTS-1:0] grant_src_i,
	input  logic               [noc_pkg::NUM_PORTS-1:0] send_i,
	output logic               [noc_pkg::NUM_PORTS-1:0] pop_o,
	output logic               [noc_pkg::NUM_PORTS-1:0] out_valid_o,
	output noc_pkg::flit_t     [noc_pkg::NUM_PORTS-1:0] out_flit_o
);

	import noc_pkg::*;

	// pop_mat[input][output] marks output sending from input.
	logic [NUM_PORTS-1:0][NUM_PORTS-1:0] pop_mat;

	always_comb begin
		for (int i = 0; i < NUM_PORTS; i++) begin
			for (int j = 0; j < NUM_PORTS; j++) begin
				pop_mat[i][j] = send_i[j] && (grant_src_i[j] == port_idx_t'(i));
			end
			pop_o[i] = |pop_mat[i]; // also the flit-sent strobe.
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			out_valid_o <= '0;
		end else begin
			out_valid_o <= send_i;
		end
	end

	always_ff @(posedge clk) begin
		for (int j = 0; j < NUM_PORTS; j++) begin
			if (send_i[j]) begin
				out_flit_o[j] <= flits_i[grant_src_i[j]];
			end
		end
	end

	// whole-packet grants mean one input feeds at most one output.
	generate
		for (genvar i = 0; i < NUM_PORTS; i++) begin : g_pop_chk
			a_single_pop: assert property (@(posedge clk) disable iff (reset_i)
				$onehot0(pop_mat[i]))
				else $error("crossbar: input %0d popped by two outputs", i);
		end
	endgenerate

	a_send_granted: assert property (@(posedge clk) disable iff (reset_i)
		(send_i & ~grant_valid_i) == '0)
		else $error("crossbar: send strobe without a grant");

endmodule

// ==== hw/router_top.sv ====
`timescale 1ns/1ps

module router_top #(
	parameter int FIFO_DEPTH = 4,
	parameter int PKT_FLITS  = 4,
	parameter int ROUTER_X   = 2,
	parameter int ROUTER_Y   = 2
) (
	input  logic                                     clk,
	input  logic                                     reset_i,
	input  logic           [noc_pkg::NUM_PORTS-1:0] in_valid_i,
	input  noc_pkg::flit_t [noc_pkg::NUM_PORTS-1:0] in_flit_i,
	input  logic           [noc_pkg::NUM_PORTS-1:0] out_credit_i,
	output logic           [noc_pkg::NUM_PORTS-1:0] in_credit_o,
	output logic           [noc_pkg::NUM_PORTS-1:0] out_valid_o,
	output noc_pkg::flit_t [noc_pkg::NUM_PORTS-1:0] out_flit_o
);

	import noc_pkg::*;

	flit_t     [NUM_PORTS-1:0] head_flit;   // buffer heads, per input.
	logic      [NUM_PORTS-1:0] not_empty;
	logic      [NUM_PORTS-1:0] pop;         // pop and flit-sent, per input.
	route_t    [NUM_PORTS-1:0] routes;
	logic      [NUM_PORTS-1:0] grant_valid; // per output.
	port_idx_t [NUM_PORTS-1:0] grant_src;
	logic      [NUM_PORTS-1:0] send;

	generate
		for (genvar i = 0; i < NUM_PORTS; i++) begin : g_input
			flit_fifo #(
				.FIFO_DEPTH(FIFO_DEPTH)
			) u_flit_fifo (
				.clk        (clk),
				.reset_i    (reset_i),
				.wr_i       (in_valid_i[i]),
				.wr_flit_i  (in_flit_i[i]),
				.pop_i      (pop[i]),
				.head_flit_o(head_flit[i]),
				.not_empty_o(not_empty[i]),
				.credit_o   (in_credit_o[i])
			);

			route_decode #(
				.PKT_FLITS(PKT_FLITS),
				.ROUTER_X (ROUTER_X),
				.ROUTER_Y (ROUTER_Y),
				.IN_PORT  (port_idx_t'(i))
			) u_route_decode (
				.clk        (clk),
				.reset_i    (reset_i),
				.head_flit_i(head_flit[i]),
				.not_empty_i(not_empty[i]),
				.sent_i     (pop[i]),
				.route_o    (routes[i])
			);
		end

		for (genvar j = 0; j < NUM_PORTS; j++) begin : g_output
			output_arbiter #(
				.FIFO_DEPTH(FIFO_DEPTH),
				.PKT_FLITS (PKT_FLITS),
				.OUT_PORT  (port_idx_t'(j))
			) u_output_arbiter (
				.clk          (clk),
				.reset_i      (reset_i),
				.routes_i     (routes),
				.not_empty_i  (not_empty),
				.credit_i     (out_credit_i[j]),
				.grant_valid_o(grant_valid[j]),
				.grant_src_o  (grant_src[j]),
				.send_o       (send[j])
			);
		end
	endgenerate

	crossbar u_crossbar (
		.clk          (clk),
		.reset_i      (reset_i),
		.flits_i      (head_flit),
		.grant_valid_i(grant_valid),
		.grant_src_i  (grant_src),
		.send_i       (send),
		.pop_o        (pop),
		.out_valid_o  (out_valid_o),
		.out_flit_o   (out_flit_o)
	);

endmodule

// ==== dv/router_tb.sv ====
`timescale 1ns/1ps

module router_tb;

	import noc_pkg::*;

	localparam int FIFO_DEPTH = 4;
	localparam int PKT_FLITS  = 4;
	localparam int MY_X       = 2;
	localparam int MY_Y       = 2;
	localparam int MAX_PKTS   = 64;
	localparam int STALL_OUT  = int'(PORT_E); // output held without credits.

	logic                  clk = 1'b0;
	logic                  reset = 1'b1;
	logic  [NUM_PORTS-1:0] in_valid = '0;
	flit_t [NUM_PORTS-1:0] in_flit = '0;
	logic  [NUM_PORTS-1:0] out_credit = '0;
	logic  [NUM_PORTS-1:0] in_credit;
	logic  [NUM_PORTS-1:0] out_valid;
	flit_t [NUM_PORTS-1:0] out_flit;
	logic  [NUM_PORTS-1:0] stall = '0;
	logic  [31:0]          lcg_state = 32'hdf7cfdb8;

	// packet state is 1 until the head arrives, 2 in flight and 3 once delivered.
	int pkt_in[MAX_PKTS], pkt_x[MAX_PKTS], pkt_y[MAX_PKTS], pkt_data[MAX_PKTS];
	int pkt_out[MAX_PKTS], pkt_state[MAX_PKTS], snd_q[MAX_PKTS];
	int crd[NUM_PORTS], crd_pulses[NUM_PORTS], flits_sent[NUM_PORTS];
	int snd_pkt[NUM_PORTS], snd_k[NUM_PORTS], owed[NUM_PORTS], dly[NUM_PORTS];
	int cur_pkt[NUM_PORTS], cur_k[NUM_PORTS], last_winner[NUM_PORTS], stall_flits[NUM_PORTS];
	int n_pkts, err_cnt, tests_passed, tests_failed, cycle_cnt, cycle_limit;
	bit rr_on;

	router_top #(
		.FIFO_DEPTH(FIFO_DEPTH),
		.PKT_FLITS (PKT_FLITS),
		.ROUTER_X  (MY_X),
		.ROUTER_Y  (MY_Y)
	) u_router_top (
		.clk         (clk),
		.reset_i     (reset),
		.in_valid_i  (in_valid),
		.in_flit_i   (in_flit),
		.out_credit_i(out_credit),
		.in_credit_o (in_credit),
		.out_valid_o (out_valid),
		.out_flit_o  (out_flit)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// row first, then column.
	function automatic int yx_port(input int x, input int y);
		if (y > MY_Y) return int'(PORT_N);
		if (y < MY_Y) return int'(PORT_S);
		if (x > MY_X) return int'(PORT_E);
		if (x < MY_X) return int'(PORT_W);
		return int'(PORT_L);
	endfunction

	// next input after the last winner that still owes this output a packet.
	function automatic int next_src(input int o);
		int c;
		for (int k = 1; k <= NUM_PORTS; k++) begin
			c = (last_winner[o] + k) % NUM_PORTS;
			for (int p = 0; p < n_pkts; p++) begin
				if (pkt_state[p] == 1 && pkt_out[p] == o && pkt_in[p] == c) return c;
			end
		end
		return -1;
	endfunction

	function automatic int count_left(input int g, input int skip_out);
		int n;
		n = 0;
		for (int p = 0; p < n_pkts; p++) begin
			if ((pkt_data[p] >> 12) == g && pkt_out[p] != skip_out && pkt_state[p] != 3) begin
				n++;
			end
		end
		return n;
	endfunction

	task automatic check_flit(input int o, input int p, input int k, input flit_t f);
		assert (f.head == (k == 0)) else begin
			$display("FAILED t=%0t out_flit_o[%0d].head got %0b expected %0b",
				$time, o, f.head, k == 0);
			err_cnt++;
		end
		assert (int'(f.dst_x) == pkt_x[p] && int'(f.dst_y) == pkt_y[p]) else begin
			$display("FAILED t=%0t out_flit_o[%0d].dst got %0d,%0d expected %0d,%0d",
				$time, o, f.dst_x, f.dst_y, pkt_x[p], pkt_y[p]);
			err_cnt++;
		end
		assert (int'(f.data) == pkt_data[p] + k) else begin
			$display("FAILED t=%0t out_flit_o[%0d].data got %h expected %h",
				$time, o, f.data, pkt_data[p] + k);
			err_cnt++;
		end
	endtask

	// senders spend one credit per flit.
	always @(posedge clk) begin
		logic  [NUM_PORTS-1:0] v;
		flit_t [NUM_PORTS-1:0] fl;
		int p;
		v = '0;
		fl = '0;
		for (int i = 0; i < NUM_PORTS; i++) begin
			if (in_credit[i] === 1'b1) begin
				crd[i]++;
				crd_pulses[i]++;
				assert (crd[i] <= FIFO_DEPTH) else begin
					$display("input %0d returned more credits than flits it was sent", i);
					err_cnt++;
				end
			end
			if (snd_pkt[i] < 0) begin
				for (int q = n_pkts - 1; q >= 0; q--) begin
					if (snd_q[q] == 1 && pkt_in[q] == i) snd_pkt[i] = q;
				end
				snd_k[i] = 0;
			end
			p = snd_pkt[i];
			if (p >= 0 && crd[i] > 0) begin
				v[i] = 1'b1;
				fl[i].head  = (snd_k[i] == 0);
				fl[i].dst_x = COORD_W'(pkt_x[p]);
				fl[i].dst_y = COORD_W'(pkt_y[p]);
				fl[i].data  = DATA_W'(pkt_data[p] + snd_k[i]);
				crd[i]--;
				flits_sent[i]++;
				snd_k[i]++;
				if (snd_k[i] == PKT_FLITS) begin
					snd_q[p] = 2;
					snd_pkt[i] = -1;
				end
			end
		end
		in_valid <= v;
		in_flit  <= fl;
	end

	// scoreboard and downstream sinks.
	always @(posedge clk) begin
		logic [NUM_PORTS-1:0] c;
		int p;
		c = '0;
		for (int o = 0; o < NUM_PORTS; o++) begin
			if (out_valid[o] === 1'b1) begin
				owed[o]++;
				if (stall[o]) stall_flits[o]++;
				assert (owed[o] <= FIFO_DEPTH) else begin
					$display("output %0d sent more flits than the downstream buffer holds", o);
					err_cnt++;
				end
				if (cur_pkt[o] < 0) begin
					p = -1;
					for (int q = 0; q < n_pkts; q++) begin
						if (pkt_state[q] == 1 && pkt_out[q] == o &&
							pkt_data[q] == int'(out_flit[o].data)) p = q;
					end
					assert (p >= 0) else begin
						$display("output %0d delivered flit %h that starts no expected packet",
							o, out_flit[o].data);
						err_cnt++;
					end
					if (p >= 0 && rr_on) begin
						assert (pkt_in[p] == next_src(o)) else begin
							$display("FAILED t=%0t grant_src of output %0d got %0d expected %0d",
								$time, o, pkt_in[p], next_src(o));
							err_cnt++;
						end
					end
					if (p >= 0) begin
						pkt_state[p] = 2;
						last_winner[o] = pkt_in[p];
						cur_pkt[o] = p;
						cur_k[o] = 0;
					end
				end
				if (cur_pkt[o] >= 0) begin
					check_flit(o, cur_pkt[o], cur_k[o], out_flit[o]);
					cur_k[o]++;
					if (cur_k[o] == PKT_FLITS) begin
						pkt_state[cur_pkt[o]] = 3;
						cur_pkt[o] = -1;
					end
				end
			end
			if (!stall[o] && owed[o] > 0 && dly[o] == 0) begin
				c[o] = 1'b1;
				owed[o]--;
				lcg_state = lcg_next(lcg_state);
				dly[o] = int'(lcg_state[31:30]); // 0 to 3 idle cycles.
			end else if (dly[o] > 0) begin
				dly[o]--;
			end
		end
		out_credit <= c;
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("timeout: packets still undelivered after %0d cycles", cycle_cnt);
			$display(">>> FAIL");
			$finish;
		end
	end

	task automatic load_packets(output bit ok);
		logic [8*96-1:0] line;
		int fd, a_in, a_x, a_y, a_d, a_o;
		fd = $fopen("dv/router_input.txt", "r");
		ok = (fd != 0);
		n_pkts = 0;
		while (ok && !$feof(fd) && n_pkts < MAX_PKTS) begin
			line = '0;
			if ($fgets(line, fd) != 0 &&
				$sscanf(line, "%h %h %h %h %h", a_in, a_x, a_y, a_d, a_o) == 5) begin
				pkt_in[n_pkts] = a_in;
				pkt_x[n_pkts] = a_x;
				pkt_y[n_pkts] = a_y;
				pkt_data[n_pkts] = a_d;
				pkt_out[n_pkts] = a_o;
				assert (a_o == yx_port(a_x, a_y)) else begin
					$display("packet %0d lists output %0d against the YX rule", n_pkts, a_o);
					err_cnt++;
				end
				n_pkts++;
			end
		end
		if (ok) $fclose(fd);
		ok = ok && (n_pkts > 0);
	endtask

	task automatic enqueue_group(input int g);
		@(negedge clk);
		for (int p = 0; p < n_pkts; p++) begin
			if ((pkt_data[p] >> 12) == g) begin
				pkt_state[p] = 1;
				snd_q[p] = 1;
			end
		end
	endtask

	task automatic wait_group(input int g, input int skip_out);
		while (count_left(g, skip_out) > 0) @(posedge clk);
	endtask

	task automatic finish_test(input string name, input int start);
		if (err_cnt == start) begin
			$display("test %s: passed", name);
			tests_passed++;
		end else begin
			$display("test %s: failed with %0d errors", name, err_cnt - start);
			tests_failed++;
		end
	endtask

	task automatic run_tests();
		int start;
		start = err_cnt;
		for (int c = 0; c < 12; c++) begin
			@(posedge clk);
			if (c == 7) reset <= 1'b0; // eight cycles in reset.
			assert (c == 0 || (out_valid == '0 && in_credit == '0)) else begin
				$display("FAILED t=%0t out_valid_o/in_credit_o got %b/%b expected 0/0",
					$time, out_valid, in_credit);
				err_cnt++;
			end
		end
		finish_test("reset", start);

		start = err_cnt;
		enqueue_group(1);
		wait_group(1, -1);
		finish_test("routing", start);

		start = err_cnt;
		rr_on = 1'b1;
		enqueue_group(2);
		wait_group(2, -1);
		rr_on = 1'b0;
		finish_test("round-robin", start);

		start = err_cnt;
		@(negedge clk);
		stall[STALL_OUT] = 1'b1;
		enqueue_group(3);
		wait_group(3, STALL_OUT); // other outputs must still drain.
		repeat (4 * PKT_FLITS) @(posedge clk);
		@(negedge clk);
		assert (stall_flits[STALL_OUT] <= FIFO_DEPTH) else begin
			$display("FAILED t=%0t out_valid_o[%0d] flits got %0d expected at most %0d",
				$time, STALL_OUT, stall_flits[STALL_OUT], FIFO_DEPTH);
			err_cnt++;
		end
		stall[STALL_OUT] = 1'b0;
		wait_group(3, -1);
		finish_test("back-pressure", start);

		start = err_cnt;
		repeat (8) @(posedge clk);
		@(negedge clk);
		for (int i = 0; i < NUM_PORTS; i++) begin
			assert (crd_pulses[i] == flits_sent[i]) else begin
				$display("FAILED t=%0t in_credit_o[%0d] pulses got %0d expected %0d",
					$time, i, crd_pulses[i], flits_sent[i]);
				err_cnt++;
			end
		end
		finish_test("credit return", start);

		$display("summary: %0d tests passed, %0d tests failed, %0d errors",
			tests_passed, tests_failed, err_cnt);
		if (tests_failed == 0 && err_cnt == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	endtask

	initial begin
		bit ok;
		for (int i = 0; i < NUM_PORTS; i++) begin
			crd[i] = FIFO_DEPTH;
			snd_pkt[i] = -1;
			cur_pkt[i] = -1;
			last_winner[i] = int'(PORT_L); // pointers start at north.
		end
		load_packets(ok);
		if (!ok) begin
			$display("could not read any packet from dv/router_input.txt");
			$display(">>> FAIL");
			$finish;
		end else begin
			cycle_limit = (n_pkts * PKT_FLITS * 4 + 200) * 8;
			run_tests();
		end
	end

endmodule

// ==== dv/router_input.txt ====
// columns: input port, dst_x, dst_y, first payload (hex), expected output port
// ports: 0 north, 1 south, 2 west, 3 east, 4 local; payload top digit is the test group
4 2 4 1000 0
4 2 0 1010 1
4 0 2 1020 2
4 5 2 1030 3
0 2 2 1040 4
0 2 1 1050 1
1 3 6 1060 0
1 1 2 1070 2
2 4 2 1080 3
2 7 7 1090 0
3 0 2 10a0 2
3 6 0 10b0 1
2 2 2 10c0 4
1 7 2 10d0 3
0 2 2 2000 4
1 2 2 2010 4
2 2 2 2020 4
3 2 2 2030 4
0 2 2 2040 4
1 2 2 2050 4
2 2 2 2060 4
3 2 2 2070 4
2 5 2 3000 3
0 4 2 3010 3
1 2 5 3020 0
4 0 2 3030 2
1 2 2 3040 4
4 3 0 3050 1

// ==== compile.f ====
common/noc_pkg.sv
hw/flit_fifo.sv
hw/route/route_decode.sv
hw/arbiter/output_arbiter.sv
hw/crossbar.sv
hw/router_top.sv
dv/router_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module router_tb -f compile.f

run: build
	./obj_dir/Vrouter_tb | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

lint:
	verilator --lint-only -Wall --timing --top-module router_top -f compile.f

clean:
	rm -rf obj_dir $(LOG)
